// ==== fwd_gen_pkg.sv ====
// --------------------------------------
// Forward data generator package
// Packet field widths, FIFO defaults and
// the run controller state encoding
// --------------------------------------

package fwd_gen_pkg;

// --------------------------------------
// Packet fields
// --------------------------------------
localparam int HOPS_W = 8;
localparam int DEST_W = 2;
localparam int ADDR_W = 32;
localparam int DATA_W = 32;

// FIFO word is {hops, dest, addr, data}, hops on top
localparam int PKT_W    = HOPS_W + DEST_W + ADDR_W + DATA_W;
localparam int HOPS_LSB = DEST_W + ADDR_W + DATA_W;
localparam int DEST_LSB = ADDR_W + DATA_W;
localparam int ADDR_LSB = DATA_W;
localparam int DATA_LSB = 0;

// --------------------------------------
// FIFO defaults
// --------------------------------------
localparam int DEF_FIFO_DEPTH  = 16;
localparam int DEF_PROG_THRESH = 8;

// --------------------------------------
// Run controller states
// --------------------------------------
typedef enum logic [3:0] {
    GEN_RESET,
    GEN_IDLE,
    GEN_SETUP_IDLE,
    GEN_SETUP_REQ,
    GEN_SETUP_WAIT,
    GEN_START,
    GEN_BUSY,
    GEN_PAUSE,
    GEN_DRAIN,
    GEN_DONE
} gen_state_e;

endpackage : fwd_gen_pkg

// ==== sync_fifo.sv ====
// --------------------------------------
// Synchronous first-word-fall-through FIFO
// Head word always on dout, with empty,
// full and programmable-full flags
// --------------------------------------

`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH       = 32,
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

logic [WIDTH-1:0] mem [DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic             do_push;
logic             do_pop;

// Pointer wrap also covers depths that are not a power of two
function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
        nxt = '0;
    end else begin
        nxt = ptr + 1'b1;
    end
    return nxt;
endfunction

// --------------------------------------
// Flags
// --------------------------------------
assign empty     = (count == '0);
assign full      = (int'(count) == DEPTH);
assign prog_full = (int'(count) >= PROG_THRESH);

assign do_push = push & ~full;
assign do_pop  = pop & ~empty;

// Head word visible without a read request
assign dout = mem[rd_ptr];

// --------------------------------------
// Pointers and occupancy
// --------------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
        end
        if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
        end
        case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

always_ff @(posedge ap_clk) begin
    if (do_push) begin
        mem[wr_ptr] <= din;
    end
end

// Upstream flow control must keep these from happening
a_no_push_when_full : assert property (@(posedge ap_clk) disable iff (areset_generator)
    !(push && full))
    else $error("sync_fifo push while full");

a_no_pop_when_empty : assert property (@(posedge ap_clk) disable iff (areset_generator)
    !(pop && empty))
    else $error("sync_fifo pop while empty");

endmodule : sync_fifo

// ==== fwd_gen_control.sv ====
// --------------------------------------
// Forward generator run controller
// Descriptor capture, configuration request,
// pause on back-pressure and completion
// --------------------------------------

`timescale 1ns/1ps

module fwd_gen_control (
    input  logic                           ap_clk,
    input  logic                           areset_generator,
    input  logic                           descriptor_valid,
    input  logic                           config_ready,
    input  logic                           config_valid,
    input  logic [fwd_gen_pkg::HOPS_W-1:0] config_hops,
    input  logic                           in_empty,
    input  logic                           stage_idle,
    input  logic                           out_empty,
    input  logic                           out_prog_full,
    output logic                           gen_enable,
    output logic [fwd_gen_pkg::HOPS_W-1:0] cfg_hops,
    output logic                           configure_memory_setup,
    output logic                           done
);

import fwd_gen_pkg::*;

gen_state_e state;
gen_state_e next_state;

// --------------------------------------
// State register
// --------------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        state <= GEN_RESET;
    end else begin
        state <= next_state;
    end
end

// --------------------------------------
// Next state
// --------------------------------------
always_comb begin
    next_state = state;
    case (state)
        GEN_RESET: begin
            next_state = GEN_IDLE;
        end
        GEN_IDLE: begin
            if (descriptor_valid) begin
                next_state = GEN_SETUP_IDLE;
            end
        end
        GEN_SETUP_IDLE: begin
            if (config_ready) begin
                next_state = GEN_SETUP_REQ;
            end
        end
        GEN_SETUP_REQ: begin
            next_state = GEN_SETUP_WAIT;
        end
        GEN_SETUP_WAIT: begin
            if (config_valid) begin
                next_state = GEN_START;
            end
        end
        GEN_START: begin
            next_state = GEN_BUSY;
        end
        GEN_BUSY: begin
            // End of run wins over a pause
            if (!descriptor_valid) begin
                next_state = GEN_DRAIN;
            end else if (out_prog_full) begin
                next_state = GEN_PAUSE;
            end
        end
        GEN_PAUSE: begin
            if (!out_prog_full) begin
                next_state = GEN_BUSY;
            end
        end
        GEN_DRAIN: begin
            if (in_empty && stage_idle && out_empty) begin
                next_state = GEN_DONE;
            end
        end
        GEN_DONE: begin
            next_state = GEN_IDLE;
        end
        default: begin
            next_state = GEN_RESET;
        end
    endcase
end

// Forward stage only pops in these two states
assign gen_enable = (state == GEN_START) || (state == GEN_BUSY);

// --------------------------------------
// Hop configuration
// --------------------------------------
// All ones outside a run, so nothing passes unreduced
always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        cfg_hops <= '1;
    end else if ((state == GEN_SETUP_WAIT) && config_valid) begin
        cfg_hops <= config_hops;
    end else if (state == GEN_DONE) begin
        cfg_hops <= '1;
    end
end

// --------------------------------------
// Registered pulses
// --------------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        configure_memory_setup <= 1'b0;
        done                   <= 1'b0;
    end else begin
        configure_memory_setup <= (state == GEN_SETUP_REQ);
        done                   <= (state == GEN_DONE);
    end
end

// One request per run, never a held level
a_setup_single_pulse : assert property (@(posedge ap_clk) disable iff (areset_generator)
    configure_memory_setup |=> !configure_memory_setup)
    else $error("configure_memory_setup held for more than one cycle");

endmodule : fwd_gen_control

// ==== hop_forward_stage.sv ====
// --------------------------------------
// Hop forward stage
// Drops zero-hop packets and reduces the
// hop count of the rest, saturating at zero
// --------------------------------------

`timescale 1ns/1ps

module hop_forward_stage (
    input  logic                           ap_clk,
    input  logic                           areset_generator,
    input  logic                           in_empty,
    input  logic [ fwd_gen_pkg::PKT_W-1:0] in_word,
    input  logic                           gen_enable,
    input  logic [fwd_gen_pkg::HOPS_W-1:0] cfg_hops,
    output logic                           in_pop,
    output logic                           fwd_valid,
    output logic [ fwd_gen_pkg::PKT_W-1:0] fwd_word,
    output logic                           stage_idle
);

import fwd_gen_pkg::*;

logic [HOPS_W-1:0] in_hops;
logic [DEST_W-1:0] in_dest;
logic [ADDR_W-1:0] in_addr;
logic [DATA_W-1:0] in_data;
logic [HOPS_W-1:0] new_hops;
logic              hops_live;

// --------------------------------------
// Unpack head word
// --------------------------------------
assign in_hops = in_word[HOPS_LSB +: HOPS_W];
assign in_dest = in_word[DEST_LSB +: DEST_W];
assign in_addr = in_word[ADDR_LSB +: ADDR_W];
assign in_data = in_word[DATA_LSB +: DATA_W];

assign hops_live = |in_hops;

// Saturating subtract
assign new_hops = (in_hops >= cfg_hops) ? (in_hops - cfg_hops) : '0;

// --------------------------------------
// Pop control
// --------------------------------------
// No pop while a forwarded packet is still in the holding register
assign in_pop     = ~in_empty & gen_enable & ~fwd_valid;
assign stage_idle = ~fwd_valid;

always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        fwd_valid <= 1'b0;
    end else begin
        fwd_valid <= in_pop & hops_live;
    end
end

// Holding register keeps the last packet between pops
always_ff @(posedge ap_clk) begin
    if (in_pop && hops_live) begin
        fwd_word <= {new_hops, in_dest, in_addr, in_data};
    end
end

endmodule : hop_forward_stage

// ==== forward_data_generator.sv ====
// --------------------------------------
// Forward data generator, top level
// Registers the inputs, buffers packets in two
// FIFOs and forwards them with reduced hops
// --------------------------------------

`timescale 1ns/1ps

module forward_data_generator #(
    parameter int FIFO_DEPTH  = fwd_gen_pkg::DEF_FIFO_DEPTH,
    parameter int PROG_THRESH = fwd_gen_pkg::DEF_PROG_THRESH
) (
    input  logic                           ap_clk,
    input  logic                           areset_generator,
    input  logic                           descriptor_valid,
    input  logic                           config_ready,
    input  logic                           config_valid,
    input  logic [fwd_gen_pkg::HOPS_W-1:0] config_hops,
    input  logic                           response_valid,
    input  logic [fwd_gen_pkg::HOPS_W-1:0] response_hops,
    input  logic [fwd_gen_pkg::DEST_W-1:0] response_dest,
    input  logic [fwd_gen_pkg::ADDR_W-1:0] response_addr,
    input  logic [fwd_gen_pkg::DATA_W-1:0] response_data,
    output logic                           response_full,
    input  logic                           request_ready,
    output logic                           request_valid,
    output logic [fwd_gen_pkg::HOPS_W-1:0] request_hops,
    output logic [fwd_gen_pkg::DEST_W-1:0] request_dest,
    output logic [fwd_gen_pkg::ADDR_W-1:0] request_addr,
    output logic [fwd_gen_pkg::DATA_W-1:0] request_data,
    output logic                           configure_memory_setup,
    output logic                           done
);

import fwd_gen_pkg::*;

// Near-full level of the input FIFO, one slot short of full
localparam int IN_NEAR_FULL = (FIFO_DEPTH > 1) ? FIFO_DEPTH - 1 : 1;

logic              descriptor_valid_reg;
logic              config_ready_reg;
logic              config_valid_reg;
logic [HOPS_W-1:0] config_hops_reg;
logic              response_valid_reg;
logic [PKT_W-1:0]  response_word_reg;
logic              request_ready_reg;

logic [PKT_W-1:0]  in_dout;
logic              in_pop;
logic              in_empty;
logic              in_full;
logic              in_near_full;

logic              gen_enable;
logic [HOPS_W-1:0] cfg_hops;
logic              stage_idle;
logic              fwd_valid;
logic [PKT_W-1:0]  fwd_word;

logic [PKT_W-1:0]  out_dout;
logic              out_pop;
logic              out_empty;
logic              out_prog_full;

// --------------------------------------
// Input registers
// --------------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        descriptor_valid_reg <= 1'b0;
        config_ready_reg     <= 1'b0;
        config_valid_reg     <= 1'b0;
        response_valid_reg   <= 1'b0;
        request_ready_reg    <= 1'b0;
    end else begin
        descriptor_valid_reg <= descriptor_valid;
        config_ready_reg     <= config_ready;
        config_valid_reg     <= config_valid;
        response_valid_reg   <= response_valid;
        request_ready_reg    <= request_ready;
    end
end

always_ff @(posedge ap_clk) begin
    config_hops_reg   <= config_hops;
    response_word_reg <= {response_hops, response_dest, response_addr, response_data};
end

// Near-full covers the word already sitting in the input register
assign response_full = in_full | in_near_full;

sync_fifo #(
    .WIDTH      (PKT_W       ),
    .DEPTH      (FIFO_DEPTH  ),
    .PROG_THRESH(IN_NEAR_FULL)
) u_in_fifo (
    .ap_clk          (ap_clk            ),
    .areset_generator(areset_generator  ),
    .push            (response_valid_reg),
    .din             (response_word_reg ),
    .pop             (in_pop            ),
    .dout            (in_dout           ),
    .empty           (in_empty          ),
    .full            (in_full           ),
    .prog_full       (in_near_full      )
);

// --------------------------------------
// Control and forward stage
// --------------------------------------
fwd_gen_control u_control (
    .ap_clk                (ap_clk                ),
    .areset_generator      (areset_generator      ),
    .descriptor_valid      (descriptor_valid_reg  ),
    .config_ready          (config_ready_reg      ),
    .config_valid          (config_valid_reg      ),
    .config_hops           (config_hops_reg       ),
    .in_empty              (in_empty              ),
    .stage_idle            (stage_idle            ),
    .out_empty             (out_empty             ),
    .out_prog_full         (out_prog_full         ),
    .gen_enable            (gen_enable            ),
    .cfg_hops              (cfg_hops              ),
    .configure_memory_setup(configure_memory_setup),
    .done                  (done                  )
);

hop_forward_stage u_forward (
    .ap_clk          (ap_clk          ),
    .areset_generator(areset_generator),
    .in_empty        (in_empty        ),
    .in_word         (in_dout         ),
    .gen_enable      (gen_enable      ),
    .cfg_hops        (cfg_hops        ),
    .in_pop          (in_pop          ),
    .fwd_valid       (fwd_valid       ),
    .fwd_word        (fwd_word        ),
    .stage_idle      (stage_idle      )
);

// --------------------------------------
// Output FIFO and request port
// --------------------------------------
sync_fifo #(
    .WIDTH      (PKT_W      ),
    .DEPTH      (FIFO_DEPTH ),
    .PROG_THRESH(PROG_THRESH)
) u_out_fifo (
    .ap_clk          (ap_clk          ),
    .areset_generator(areset_generator),
    .push            (fwd_valid       ),
    .din             (fwd_word        ),
    .pop             (out_pop         ),
    .dout            (out_dout        ),
    .empty           (out_empty       ),
    .full            (                ),
    .prog_full       (out_prog_full   )
);

assign out_pop = ~out_empty & request_ready_reg;

always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        request_valid <= 1'b0;
    end else begin
        request_valid <= out_pop;
    end
end

// Payload holds its last value between strobes
always_ff @(posedge ap_clk) begin
    if (out_pop) begin
        request_hops <= out_dout[HOPS_LSB +: HOPS_W];
        request_dest <= out_dout[DEST_LSB +: DEST_W];
        request_addr <= out_dout[ADDR_LSB +: ADDR_W];
        request_data <= out_dout[DATA_LSB +: DATA_W];
    end
end

endmodule : forward_data_generator

// ==== tb_forward_data_generator.sv ====
// --------------------------------------
// Testbench for the forward data generator
// Two runs with random traffic, a stall phase,
// scoreboard queue and concurrent checks
// --------------------------------------

`timescale 1ns/1ps

module tb_forward_data_generator;

import fwd_gen_pkg::*;

localparam int NUM_PACKETS     = 40;
localparam int STALL_CYCLES    = 60;
localparam int NUM_TESTS       = 6;
localparam int CYCLES_PER_TEST = 2000;
localparam int SEED            = 90167;
localparam logic [HOPS_W-1:0] CFG_RUN1 = 8'd3;
localparam logic [HOPS_W-1:0] CFG_RUN2 = 8'd7;

logic              ap_clk;
logic              areset_generator;
logic              descriptor_valid;
logic              config_ready;
logic              config_valid;
logic [HOPS_W-1:0] config_hops;
logic              response_valid;
logic [HOPS_W-1:0] response_hops;
logic [DEST_W-1:0] response_dest;
logic [ADDR_W-1:0] response_addr;
logic [DATA_W-1:0] response_data;
logic              response_full;
logic              request_ready;
logic              request_valid;
logic [HOPS_W-1:0] request_hops;
logic [DEST_W-1:0] request_dest;
logic [ADDR_W-1:0] request_addr;
logic [DATA_W-1:0] request_data;
logic              configure_memory_setup;
logic              done;

// Scoreboard and check windows
logic [PKT_W-1:0]  expected_q[$];
logic [PKT_W-1:0]  exp_word;
logic              unexpected;
logic              quiet_window;
logic              setup_window;
logic              done_window;
logic              stall_window;
logic              after_done;
logic              full_seen;
logic [HOPS_W-1:0] run_cfg;
integer            seed;
integer            setup_count;
integer            done_count;
integer            error_count;
integer            errors_mark;
integer            tests_passed;
integer            tests_failed;

forward_data_generator #(
    .FIFO_DEPTH (DEF_FIFO_DEPTH ),
    .PROG_THRESH(DEF_PROG_THRESH)
) i_forward_data_generator (
    .ap_clk                (ap_clk                ),
    .areset_generator      (areset_generator      ),
    .descriptor_valid      (descriptor_valid      ),
    .config_ready          (config_ready          ),
    .config_valid          (config_valid          ),
    .config_hops           (config_hops           ),
    .response_valid        (response_valid        ),
    .response_hops         (response_hops         ),
    .response_dest         (response_dest         ),
    .response_addr         (response_addr         ),
    .response_data         (response_data         ),
    .response_full         (response_full         ),
    .request_ready         (request_ready         ),
    .request_valid         (request_valid         ),
    .request_hops          (request_hops          ),
    .request_dest          (request_dest          ),
    .request_addr          (request_addr          ),
    .request_data          (request_data          ),
    .configure_memory_setup(configure_memory_setup),
    .done                  (done                  )
);

initial ap_clk = 1'b0;
always #50 ap_clk = ~ap_clk;

// Hop count after the configured reduction, floored at zero
function automatic logic [HOPS_W-1:0] reduce_hops(input logic [HOPS_W-1:0] hops,
                                                  input logic [HOPS_W-1:0] cfg);
    logic [HOPS_W-1:0] result;
    if (hops < cfg) begin
        result = '0;
    end else begin
        result = hops - cfg;
    end
    return result;
endfunction

// --------------------------------------
// Output monitor, mid-cycle
// --------------------------------------
always @(negedge ap_clk) begin
    if (!areset_generator) begin
        if (request_valid) begin
            if (expected_q.size() == 0) begin
                unexpected = 1'b1;
            end else begin
                unexpected = 1'b0;
                exp_word   = expected_q.pop_front();
            end
        end
        if (configure_memory_setup) begin
            setup_count = setup_count + 1;
        end
        if (done) begin
            done_count = done_count + 1;
            after_done = 1'b1;
        end
    end
end

// --------------------------------------
// Concurrent checks
// --------------------------------------
a_reset_quiet : assert property (@(posedge ap_clk)
    quiet_window |-> (!request_valid && !configure_memory_setup && !done && !response_full))
    else begin
        $display("Error at %0t: an output was high during or just after reset", $time);
        error_count = error_count + 1;
    end

a_setup_in_window : assert property (@(posedge ap_clk) disable iff (areset_generator)
    configure_memory_setup |-> setup_window)
    else begin
        $display("Error at %0t: configure_memory_setup pulsed outside setup", $time);
        error_count = error_count + 1;
    end

a_config_after_setup : assert property (@(posedge ap_clk) disable iff (areset_generator)
    config_valid |-> (setup_count == 1))
    else begin
        $display("Error at %0t: configuration sent without exactly one request", $time);
        error_count = error_count + 1;
    end

a_request_known : assert property (@(posedge ap_clk) disable iff (areset_generator)
    request_valid |-> !unexpected)
    else begin
        $display("Mismatch at %0t: request_valid with no packet expected", $time);
        error_count = error_count + 1;
    end

a_request_matches : assert property (@(posedge ap_clk) disable iff (areset_generator)
    request_valid |-> ({request_hops, request_dest, request_addr, request_data} == exp_word))
    else begin
        $display("Mismatch at %0t: request word %h, expected %h", $time,
                 $sampled({request_hops, request_dest, request_addr, request_data}), exp_word);
        error_count = error_count + 1;
    end

a_stall_holds : assert property (@(posedge ap_clk) disable iff (areset_generator)
    stall_window |-> !request_valid)
    else begin
        $display("Error at %0t: request_valid while request_ready was low", $time);
        error_count = error_count + 1;
    end

a_done_in_window : assert property (@(posedge ap_clk) disable iff (areset_generator)
    done |-> done_window)
    else begin
        $display("Error at %0t: done pulsed outside the end of a run", $time);
        error_count = error_count + 1;
    end

a_quiet_after_done : assert property (@(posedge ap_clk) disable iff (areset_generator)
    after_done |-> !request_valid)
    else begin
        $display("Error at %0t: request_valid after done", $time);
        error_count = error_count + 1;
    end

// --------------------------------------
// Stimulus tasks
// --------------------------------------
task automatic next_cycle();
    @(posedge ap_clk);
    #1;
endtask

task automatic drive_packet(input logic force_live);
    logic [31:0] rnd;
    rnd = $random(seed);
    if ((rnd[1:0] == 2'b00) && !force_live) begin
        response_hops = '0;
    end else begin
        response_hops = HOPS_W'(rnd[7:4]) + HOPS_W'(1);
    end
    response_dest  = rnd[8 +: DEST_W];
    response_addr  = $random(seed);
    response_data  = $random(seed);
    response_valid = 1'b1;
    if (response_hops != '0) begin
        expected_q.push_back({reduce_hops(response_hops, run_cfg), response_dest,
                              response_addr, response_data});
    end
endtask

task automatic send_packet(input logic force_live);
    while (response_full) begin
        response_valid = 1'b0;
        next_cycle();
    end
    drive_packet(force_live);
    next_cycle();
    response_valid = 1'b0;
endtask

task automatic start_run(input logic [HOPS_W-1:0] cfg);
    setup_count      = 0;
    done_count       = 0;
    after_done       = 1'b0;
    setup_window     = 1'b1;
    descriptor_valid = 1'b1;
    config_ready     = 1'b1;
    next_cycle();
    while (!configure_memory_setup) begin
        next_cycle();
    end
    next_cycle();
    setup_window = 1'b0;
    run_cfg      = cfg;
    config_hops  = cfg;
    config_valid = 1'b1;
    next_cycle();
    config_valid = 1'b0;
endtask

// Last packet is live, so an empty queue means the input FIFO is drained
task automatic send_traffic(input int count);
    repeat (count) begin
        send_packet(1'b0);
    end
    send_packet(1'b1);
    while (expected_q.size() != 0) begin
        next_cycle();
    end
    repeat (3) next_cycle();
endtask

task automatic finish_run();
    done_window      = 1'b1;
    descriptor_valid = 1'b0;
    config_ready     = 1'b0;
    while (!done) begin
        next_cycle();
    end
    next_cycle();
    done_window = 1'b0;
    repeat (8) next_cycle();
    assert (done_count == 1) else begin
        $display("Error at %0t: done pulsed %0d times in one run", $time, done_count);
        error_count = error_count + 1;
    end
    assert (setup_count == 1) else begin
        $display("Error at %0t: %0d setup requests in one run", $time, setup_count);
        error_count = error_count + 1;
    end
endtask

task automatic report_test(input string name);
    if (error_count == errors_mark) begin
        $display("Test %s: PASS", name);
        tests_passed = tests_passed + 1;
    end else begin
        $display("Test %s: FAIL with %0d errors", name, error_count - errors_mark);
        tests_failed = tests_failed + 1;
    end
    errors_mark = error_count;
endtask

// --------------------------------------
// Test sequence
// --------------------------------------
initial begin
    seed             = SEED;
    areset_generator = 1'b1;
    descriptor_valid = 1'b0;
    config_ready     = 1'b0;
    config_valid     = 1'b0;
    config_hops      = '0;
    response_valid   = 1'b0;
    response_hops    = '0;
    response_dest    = '0;
    response_addr    = '0;
    response_data    = '0;
    request_ready    = 1'b1;
    exp_word         = '0;
    unexpected       = 1'b0;
    quiet_window     = 1'b0;
    setup_window     = 1'b0;
    done_window      = 1'b0;
    stall_window     = 1'b0;
    after_done       = 1'b0;
    full_seen        = 1'b0;
    run_cfg          = '1;
    setup_count      = 0;
    done_count       = 0;
    error_count      = 0;
    errors_mark      = 0;
    tests_passed     = 0;
    tests_failed     = 0;

    next_cycle();
    quiet_window = 1'b1;
    next_cycle();
    areset_generator = 1'b0;
    repeat (2) next_cycle();
    quiet_window = 1'b0;
    report_test("reset_outputs_low");

    start_run(CFG_RUN1);
    report_test("single_setup_request");

    send_traffic(NUM_PACKETS);
    report_test("forward_in_order");

    // Consumer stalls while the source keeps pushing
    request_ready = 1'b0;
    repeat (3) next_cycle();
    stall_window = 1'b1;
    repeat (STALL_CYCLES) begin
        if (response_full) begin
            full_seen      = 1'b1;
            response_valid = 1'b0;
        end else begin
            drive_packet(1'b0);
        end
        next_cycle();
    end
    response_valid = 1'b0;
    stall_window   = 1'b0;
    request_ready  = 1'b1;
    assert (full_seen) else begin
        $display("Error at %0t: response_full never rose during the stall", $time);
        error_count = error_count + 1;
    end
    send_traffic(0);
    report_test("backpressure_no_loss");

    finish_run();
    report_test("single_done_pulse");

    start_run(CFG_RUN2);
    send_traffic(NUM_PACKETS);
    finish_run();
    report_test("second_run_new_config");

    $display("Tests passed: %0d, failed: %0d, errors: %0d",
             tests_passed, tests_failed, error_count);
    if ((error_count == 0) && (tests_failed == 0)) begin
        $display("Simulation completed successfully");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

// Watchdog
initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge ap_clk);
    $display("Timeout: the run did not finish within %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("Simulation failed");
    $finish;
end

endmodule : tb_forward_data_generator

// ==== files.f ====
fwd_gen_pkg.sv
sync_fifo.sv
fwd_gen_control.sv
hop_forward_stage.sv
forward_data_generator.sv
tb_forward_data_generator.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_forward_data_generator
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
